/* fifo_top.f */
hw/fifo_pkg.sv
hw/fifo_mem_1r1w.sv
hw/fifo_ctrl.sv
hw/fifo_top.sv
tests/tb_clkgen.sv
tests/fifo_props.sv
tests/tb_fifo_top.sv

/* hw/fifo_ctrl.sv */
`timescale 1ns/1ps

module fifo_ctrl
	import fifo_pkg::*;
(
	input  logic                   clk,
	input  logic                   arst_n,

	// Strobes from producer and consumer
	input  logic                   push,
	input  logic                   pop,

	// Storage write side
	output logic [PTR_WIDTH-1:0]   mem_windex,
	output logic                   mem_wenable,
	output logic [NUM_BYTES-1:0]   mem_wpermit,

	// Storage read side
	output logic [PTR_WIDTH-1:0]   mem_rindex,
	output logic                   mem_renable,

	// Status towards the outside
	output logic                   pop_valid,
	output logic                   full,
	output logic                   empty,
	output logic [LEVEL_WIDTH-1:0] level,
	output logic                   error
);

	// ********************************************************************
	// Acceptance
	// ********************************************************************

	// Write and read pointers into the array
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;

	// Strobes that actually move data
	logic push_ok;
	logic pop_ok;

	// Occupancy after the current edge
	logic [LEVEL_WIDTH-1:0] level_next;

	// A push needs room, a pop needs a word
	assign push_ok = push & ~full;
	assign pop_ok  = pop & ~empty;

	// ********************************************************************
	// Storage strobes
	// ********************************************************************

	// Write lands at the tail in the same edge as the push
	assign mem_windex  = wr_ptr;
	assign mem_wenable = push_ok;

	// Whole words only, every byte permitted
	assign mem_wpermit = '1;

	// Head word is registered by the storage on an accepted pop
	assign mem_rindex  = rd_ptr;
	assign mem_renable = pop_ok;

	// ********************************************************************
	// Pointers
	// ********************************************************************

	// Tail pointer, wraps after the last slot
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			wr_ptr <= '0;
		else if (push_ok)
		begin
			if (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1))
				wr_ptr <= '0;
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// Head pointer, same wrap rule
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			rd_ptr <= '0;
		else if (pop_ok)
		begin
			if (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1))
				rd_ptr <= '0;
			else
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// ********************************************************************
	// Occupancy and flags
	// ********************************************************************

	// Push and pop together leave the count alone
	always_comb
	begin
		level_next = level;
		case ({push_ok, pop_ok})
			2'b10: level_next = level + 1'b1;
			2'b01: level_next = level - 1'b1;
			default: level_next = level;
		endcase
	end

	// Count and its flags all settle one edge after the strobes
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			level <= '0;
			full  <= 1'b0;
			empty <= 1'b1;
		end
		else
		begin
			level <= level_next;
			full  <= (level_next == LEVEL_WIDTH'(FIFO_DEPTH));
			empty <= (level_next == '0);
		end
	end

	// Valid marks the cycle where the popped word sits on the output
	// Error pulses once for each misused strobe
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pop_valid <= 1'b0;
			error     <= 1'b0;
		end
		else
		begin
			pop_valid <= pop_ok;
			error     <= (push & full) | (pop & empty);
		end
	end

endmodule

/* hw/fifo_mem_1r1w.sv */
`timescale 1ns/1ps

module fifo_mem_1r1w
	import fifo_pkg::*;
(
	input  logic                  clk,

	// Write side
	input  logic [PTR_WIDTH-1:0]  windex,
	input  logic                  wenable,
	input  logic [NUM_BYTES-1:0]  wpermit,
	input  logic [DATA_WIDTH-1:0] wdata,

	// Read side
	input  logic [PTR_WIDTH-1:0]  rindex,
	input  logic                  renable,
	output logic [DATA_WIDTH-1:0] rdata_async,
	output logic [DATA_WIDTH-1:0] rdata_sync
);

	// ********************************************************************
	// Storage and write mask
	// ********************************************************************

	// Entry array, one word per slot
	logic [DATA_WIDTH-1:0] mem [0:FIFO_DEPTH-1];

	// Per-bit write strobe built from enable and byte permit
	logic [DATA_WIDTH-1:0] wmask;

	// Each data bit follows the permit of the byte it sits in
	always_comb
	begin
		wmask = '0;
		if (wenable)
		begin
			for (int j = 0; j < DATA_WIDTH; j++)
			begin
				wmask[j] = wpermit[j / BYTE_WIDTH];
			end
		end
	end

	// Known contents at simulation start
	// Array itself has no reset
	initial
	begin
		for (int k = 0; k < FIFO_DEPTH; k++)
		begin
			mem[k] = '0;
		end
	end

	// Bit-granular write into the addressed entry
	// Unmasked bits keep their old value
	always @(posedge clk)
	begin
		for (int i = 0; i < DATA_WIDTH; i++)
		begin
			if (wmask[i])
				mem[windex][i] <= wdata[i];
		end
	end

	// ********************************************************************
	// Read paths
	// ********************************************************************

	// Combinational look-up of the read entry
	assign rdata_async = mem[rindex];

	// Registered copy, updated only on a read strobe
	// Holds its value between strobes
	always_ff @(posedge clk)
	begin
		if (renable)
			rdata_sync <= rdata_async;
	end

endmodule

/* hw/fifo_pkg.sv */
package fifo_pkg;

	// ********************************************************************
	// Queue geometry
	// ********************************************************************

	// Number of entries held in the storage array
	localparam int FIFO_DEPTH = 8;

	// Word width carried from producer to consumer
	localparam int DATA_WIDTH = 16;

	// Granule covered by one write permit bit
	localparam int BYTE_WIDTH = 8;

	// ********************************************************************
	// Derived widths
	// ********************************************************************

	// Permit bits per word, rounded up for a partial last granule
	localparam int NUM_BYTES = (DATA_WIDTH + BYTE_WIDTH - 1) / BYTE_WIDTH;

	// Index width for addressing every entry
	localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

	// One extra bit so the count can reach FIFO_DEPTH
	localparam int LEVEL_WIDTH = PTR_WIDTH + 1;

endpackage

/* hw/fifo_top.sv */
`timescale 1ns/1ps

module fifo_top
	import fifo_pkg::*;
(
	input  logic                   clk,
	input  logic                   arst_n,

	// Producer side
	input  logic                   push,
	input  logic [DATA_WIDTH-1:0]  push_data,

	// Consumer side
	input  logic                   pop,
	output logic [DATA_WIDTH-1:0]  pop_data,
	output logic                   pop_valid,

	// Queue status
	output logic                   full,
	output logic                   empty,
	output logic [LEVEL_WIDTH-1:0] level,
	output logic                   error
);

	// ********************************************************************
	// Controller to storage wiring
	// ********************************************************************

	logic [PTR_WIDTH-1:0] mem_windex;
	logic                 mem_wenable;
	logic [NUM_BYTES-1:0] mem_wpermit;
	logic [PTR_WIDTH-1:0] mem_rindex;
	logic                 mem_renable;

	// Pointers, count, flags and strobes
	fifo_ctrl u_fifo_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.push        (push),
		.pop         (pop),
		.mem_windex  (mem_windex),
		.mem_wenable (mem_wenable),
		.mem_wpermit (mem_wpermit),
		.mem_rindex  (mem_rindex),
		.mem_renable (mem_renable),
		.pop_valid   (pop_valid),
		.full        (full),
		.empty       (empty),
		.level       (level),
		.error       (error)
	);

	// Word storage
	// Write data comes straight from the producer
	// Popped word is taken from the registered read port
	fifo_mem_1r1w u_fifo_mem_1r1w (
		.clk         (clk),
		.windex      (mem_windex),
		.wenable     (mem_wenable),
		.wpermit     (mem_wpermit),
		.wdata       (push_data),
		.rindex      (mem_rindex),
		.renable     (mem_renable),
		.rdata_async (),
		.rdata_sync  (pop_data)
	);

endmodule

/* tests/fifo_props.sv */
`timescale 1ns/1ps

module fifo_props
	import fifo_pkg::*;
(
	input logic                   clk,
	input logic                   arst_n,
	input logic                   pop,
	input logic                   pop_valid,
	input logic                   full,
	input logic                   empty,
	input logic [LEVEL_WIDTH-1:0] level
);

	// Number of failed assertions so far
	int fail_count = 0;

	// ********************************************************************
	// Flag consistency
	// ********************************************************************

	// A queue cannot be full and empty at once
	full_empty_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(full && empty))
		else
		begin
			$error("full and empty are high together");
			fail_count++;
		end

	// Count stays within the storage size
	level_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		level <= LEVEL_WIDTH'(FIFO_DEPTH))
		else
		begin
			$error("level above queue depth");
			fail_count++;
		end

	// ********************************************************************
	// Read-valid timing
	// ********************************************************************

	// Accepted pop gives valid on the next cycle
	valid_after_pop: assert property (@(posedge clk) disable iff (!arst_n)
		(pop && !empty) |=> pop_valid)
		else
		begin
			$error("pop_valid missing after an accepted pop");
			fail_count++;
		end

	// No accepted pop, no valid
	no_valid_without_pop: assert property (@(posedge clk) disable iff (!arst_n)
		!(pop && !empty) |=> !pop_valid)
		else
		begin
			$error("pop_valid without an accepted pop");
			fail_count++;
		end

endmodule

/* tests/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen
(
	output logic clk
);

	// Half of the 8 ns period
	localparam int HALF_PERIOD_NS = 4;

	// Free-running clock, low at time zero
	initial
	begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

endmodule

/* tests/tb_fifo_top.sv */
`timescale 1ns/1ps

module tb_fifo_top
	import fifo_pkg::*;
();

	// ********************************************************************
	// Run parameters
	// ********************************************************************

	localparam int SEED          = 79592;
	localparam int RESET_CYCLES  = 10;
	localparam int PHASE_CYCLES  = 400;
	// Fill, drain, mixed and two biased phases
	localparam int NUM_PHASES    = 5;
	localparam int TIMEOUT_CYCLES = NUM_PHASES * PHASE_CYCLES + 100;
	localparam int DRIVE_DELAY   = 1;

	logic                   clk;
	logic                   arst_n;
	logic                   push;
	logic [DATA_WIDTH-1:0]  push_data;
	logic                   pop;
	logic [DATA_WIDTH-1:0]  pop_data;
	logic                   pop_valid;
	logic                   full;
	logic                   empty;
	logic [LEVEL_WIDTH-1:0] level;
	logic                   error;

	// Queue model and the outputs it predicts for the next check
	logic [DATA_WIDTH-1:0] model_q [$];
	logic                  exp_valid;
	logic                  exp_error;
	logic [DATA_WIDTH-1:0] exp_data;
	// Set by the first accepted pop
	// pop_data is unknown before it
	logic                  have_data;
	int                    cycle_count;
	int unsigned           seed_value;

	tb_clkgen u_tb_clkgen (.clk(clk));

	fifo_top u_fifo_top (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.pop_data  (pop_data),
		.pop_valid (pop_valid),
		.full      (full),
		.empty     (empty),
		.level     (level),
		.error     (error)
	);

	bind fifo_top fifo_props u_fifo_props (
		.clk       (clk),
		.arst_n    (arst_n),
		.pop       (pop),
		.pop_valid (pop_valid),
		.full      (full),
		.empty     (empty),
		.level     (level)
	);

	// ********************************************************************
	// Checking
	// ********************************************************************

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("ERR time=%0t signal=%s expected=0x%0h actual=0x%0h",
				$time, name, expected, actual);
			$display("Test failures found");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Outputs settled from the last edge against the model
	task automatic compare_outputs();
		int count;
		count = model_q.size();
		check_value("level", 32'(count), 32'(level));
		check_value("full", 32'(count == FIFO_DEPTH), 32'(full));
		check_value("empty", 32'(count == 0), 32'(empty));
		check_value("pop_valid", 32'(exp_valid), 32'(pop_valid));
		check_value("error", 32'(exp_error), 32'(error));
		// Word stays on pop_data until the next accepted pop
		if (have_data)
			check_value("pop_data", 32'(exp_data), 32'(pop_data));
	endtask

	// Any assertion failure in the bound checker ends the run
	always @(u_fifo_top.u_fifo_props.fail_count)
	begin
		if (u_fifo_top.u_fifo_props.fail_count != 0)
		begin
			$display("Assertion failure in fifo_props at time %0t", $time);
			$display("Test failures found");
			$fatal(1, "assertion failure");
		end
	end

	// ********************************************************************
	// Stimulus
	// ********************************************************************

	// One cycle of checking, new strobes and model update
	task automatic drive_cycle(input int push_pct, input int pop_pct);
		logic do_push;
		logic do_pop;
		logic was_full;
		logic was_empty;
		logic [DATA_WIDTH-1:0] word;
		@(posedge clk);
		#(DRIVE_DELAY);
		compare_outputs();
		do_push   = ($urandom % 100) < push_pct;
		do_pop    = ($urandom % 100) < pop_pct;
		word      = DATA_WIDTH'($urandom);
		push      = do_push;
		pop       = do_pop;
		push_data = word;
		was_full  = (model_q.size() == FIFO_DEPTH);
		was_empty = (model_q.size() == 0);
		// Misused strobes are ignored but flagged
		exp_error = (do_push && was_full) || (do_pop && was_empty);
		exp_valid = do_pop && !was_empty;
		// Pop is judged on the queue before this cycle's push
		if (exp_valid)
		begin
			exp_data  = model_q.pop_front();
			have_data = 1'b1;
		end
		if (do_push && !was_full)
			model_q.push_back(word);
	endtask

	task automatic run_phase(input int push_pct, input int pop_pct);
		repeat (PHASE_CYCLES)
		begin
			drive_cycle(push_pct, pop_pct);
		end
	endtask

	// ********************************************************************
	// Main sequence
	// ********************************************************************

	initial
	begin
		arst_n    = 1'b0;
		push      = 1'b0;
		pop       = 1'b0;
		push_data = '0;
		exp_valid = 1'b0;
		exp_error = 1'b0;
		exp_data  = '0;
		have_data = 1'b0;
		seed_value = $urandom(SEED);

		// Reset values are checked before release
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		compare_outputs();
		arst_n = 1'b1;

		// Fill, then drain past empty
		run_phase(75, 0);
		run_phase(0, 75);
		// Even mix, then heavy push and heavy pop for pointer wrap
		run_phase(50, 50);
		run_phase(80, 20);
		run_phase(20, 80);

		// Last driven cycle still has to be checked
		@(posedge clk);
		#(DRIVE_DELAY);
		compare_outputs();
		push = 1'b0;
		pop  = 1'b0;

		$display("All tests passed!");
		$finish;
	end

	// Cycle limit in case the sequence stalls
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failures found");
		$fatal(1, "timeout");
	end

endmodule
